// ==== verilog/sid_pkg.sv ====
// Shared constants for the three-voice SID; widths assume an 8-bit bus and a 12-bit DAC
`default_nettype none

package sid_pkg;

	localparam int num_voices = 3;

	// Datapath widths
	localparam int freq_w = 16;
	localparam int pw_w = 12;
	localparam int acc_w = 24;
	localparam int lfsr_w = 23;
	localparam int env_w = 8;

	// System clocks per sequencer tick
	localparam int tick_div = 6;

	// Register map
	localparam int addr_w = 5;
	localparam int voice_stride = 7;
	localparam int off_freq_lo = 0;
	localparam int off_freq_hi = 1;
	localparam int off_pw_lo = 2;
	localparam int off_pw_hi = 3;
	localparam int off_ctrl = 4;
	localparam int off_atk_dec = 5;
	localparam int off_sus_rel = 6;
	localparam int addr_mode = 24;
	localparam int addr_osc3 = 27;
	localparam int addr_env3 = 28;

	// Control register bits
	localparam int ctrl_bit_noise = 7;
	localparam int ctrl_bit_pulse = 6;
	localparam int ctrl_bit_saw = 5;
	localparam int ctrl_bit_triangle = 4;
	localparam int ctrl_bit_gate = 0;
	localparam int mode_three_off = 7;

	typedef enum logic [1:0] {
		env_attack,
		env_decay_sustain,
		env_release
	} env_state_t;

	// Envelope step periods in voice updates, indexed by the rate nibble
	localparam logic [14:0] rate_table [16] = '{
		15'd8, 15'd31, 15'd62, 15'd94, 15'd148, 15'd219, 15'd266, 15'd312,
		15'd391, 15'd976, 15'd1953, 15'd3125, 15'd3906, 15'd11719, 15'd19531, 15'd31250
	};

	localparam logic [3:0] dac_cmd = 4'b0111;
	localparam logic [acc_w-1:0] acc_reset = 24'h555555;
	localparam logic [lfsr_w-1:0] lfsr_reset = 23'h7fffff;

endpackage

`default_nettype wire

// ==== verilog/sid_sequencer.sv ====
// Slot sequencer; one voice slot every 48 clocks, slot 3 is idle and opens the next frame
`default_nettype none

module sid_sequencer (
	input wire clk,
	input wire rst,
	output logic tick,
	output logic [2:0] step,
	output logic [1:0] voice,
	output logic voice_update,
	output logic frame_start
);

	logic [2:0] div_cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			div_cnt <= '0;
			step <= '0;
		end else begin
			div_cnt <= (div_cnt == 3'(sid_pkg::tick_div - 1)) ? 3'd0 : div_cnt + 3'd1;
			if (tick)
				step <= step + 3'd1;
		end
	end

	assign tick = (div_cnt == 3'd0);
	assign voice = step[2:1];
	// Even steps update a voice, odd steps leave the pipeline time to settle
	assign voice_update = tick && !step[0] && (voice < 2'(sid_pkg::num_voices));
	assign frame_start = tick && (step == 3'd0);

	// A voice slot comes round again after eight steps
	a_slot_period: assert property (@(posedge clk) disable iff (rst)
		voice_update |-> ##(8 * sid_pkg::tick_div) voice_update);

endmodule

`default_nettype wire

// ==== verilog/sid_regs.sv ====
// Register file; writes land on the next edge, reads are combinational, unmapped reads give 0
`default_nettype none

module sid_regs (
	input wire clk,
	input wire rst,
	input wire write_en,
	input wire [sid_pkg::addr_w-1:0] addr,
	input wire [7:0] wdata,
	output logic [7:0] rdata,
	output logic [sid_pkg::num_voices-1:0][sid_pkg::freq_w-1:0] freq,
	output logic [sid_pkg::num_voices-1:0][sid_pkg::pw_w-1:0] pw,
	output logic [sid_pkg::num_voices-1:0][7:0] ctrl,
	output logic [sid_pkg::num_voices-1:0][7:0] atk_dec,
	output logic [sid_pkg::num_voices-1:0][7:0] sus_rel,
	output logic [7:0] mode,
	input wire [7:0] osc3,
	input wire [sid_pkg::env_w-1:0] env3
);

	always_ff @(posedge clk) begin
		if (rst) begin
			freq <= '0;
			pw <= '0;
			ctrl <= '0;
			atk_dec <= '0;
			sus_rel <= '0;
			mode <= '0;
		end else if (write_en) begin
			for (int v = 0; v < sid_pkg::num_voices; v++) begin
				case (int'(addr) - v * sid_pkg::voice_stride)
					sid_pkg::off_freq_lo: freq[v][7:0] <= wdata;
					sid_pkg::off_freq_hi: freq[v][15:8] <= wdata;
					sid_pkg::off_pw_lo: pw[v][7:0] <= wdata;
					// Only 12 pulse width bits exist
					sid_pkg::off_pw_hi: pw[v][sid_pkg::pw_w-1:8] <= wdata[3:0];
					sid_pkg::off_ctrl: ctrl[v] <= wdata;
					sid_pkg::off_atk_dec: atk_dec[v] <= wdata;
					sid_pkg::off_sus_rel: sus_rel[v] <= wdata;
					default: ;
				endcase
			end
			if (int'(addr) == sid_pkg::addr_mode)
				mode <= wdata;
		end
	end

	always_comb begin
		rdata = '0;
		for (int v = 0; v < sid_pkg::num_voices; v++) begin
			case (int'(addr) - v * sid_pkg::voice_stride)
				sid_pkg::off_freq_lo: rdata = freq[v][7:0];
				sid_pkg::off_freq_hi: rdata = freq[v][15:8];
				sid_pkg::off_pw_lo: rdata = pw[v][7:0];
				sid_pkg::off_pw_hi: rdata = {4'h0, pw[v][sid_pkg::pw_w-1:8]};
				sid_pkg::off_ctrl: rdata = ctrl[v];
				sid_pkg::off_atk_dec: rdata = atk_dec[v];
				sid_pkg::off_sus_rel: rdata = sus_rel[v];
				default: ;
			endcase
		end
		// Chip-wide registers sit above the voice blocks
		case (int'(addr))
			sid_pkg::addr_mode: rdata = mode;
			sid_pkg::addr_osc3: rdata = osc3;
			sid_pkg::addr_env3: rdata = env3;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/sid_oscillator.sv ====
// Time-multiplexed oscillator; wave is valid the cycle after voice_update, no waveform gives 0
`default_nettype none

module sid_oscillator (
	input wire clk,
	input wire rst,
	input wire voice_update,
	input wire [1:0] voice,
	input wire [sid_pkg::num_voices-1:0][sid_pkg::freq_w-1:0] freq,
	input wire [sid_pkg::num_voices-1:0][sid_pkg::pw_w-1:0] pw,
	input wire [sid_pkg::num_voices-1:0][7:0] ctrl,
	output logic [sid_pkg::pw_w-1:0] wave,
	output logic [7:0] osc3
);

	logic [sid_pkg::acc_w-1:0] acc [sid_pkg::num_voices];
	logic [sid_pkg::lfsr_w-1:0] lfsr [sid_pkg::num_voices];
	logic [1:0] vsel;
	logic [sid_pkg::acc_w-1:0] cur_acc;
	logic [sid_pkg::acc_w-1:0] acc_next;
	logic [sid_pkg::lfsr_w-1:0] cur_lfsr;
	logic [7:0] cur_ctrl;
	logic [sid_pkg::pw_w-1:0] phase;
	logic [sid_pkg::pw_w-1:0] saw_wave;
	logic [sid_pkg::pw_w-1:0] pulse_wave;
	logic [sid_pkg::pw_w-1:0] tri_wave;
	logic [sid_pkg::pw_w-1:0] noise_wave;
	logic [sid_pkg::pw_w-1:0] wave_next;

	// The idle slot maps to voice 0 but never updates anything
	assign vsel = (voice < 2'(sid_pkg::num_voices)) ? voice : 2'd0;
	assign cur_acc = acc[vsel];
	assign cur_lfsr = lfsr[vsel];
	assign cur_ctrl = ctrl[vsel];
	assign acc_next = cur_acc + sid_pkg::acc_w'(freq[vsel]);
	assign phase = cur_acc[sid_pkg::acc_w-1 -: sid_pkg::pw_w];

	assign saw_wave = phase;
	assign pulse_wave = (phase >= pw[vsel]) ? '1 : '0;
	// Fold the upper half of the ramp back down
	assign tri_wave = {cur_acc[22:12], 1'b0} ^ {sid_pkg::pw_w{cur_acc[23]}};
	assign noise_wave = {cur_lfsr[20], cur_lfsr[18], cur_lfsr[14], cur_lfsr[11],
		cur_lfsr[9], cur_lfsr[5], cur_lfsr[2], cur_lfsr[0], 4'b0000};

	always_comb begin
		wave_next = '0;
		if (|cur_ctrl[7:4]) begin
			wave_next = (cur_ctrl[sid_pkg::ctrl_bit_pulse] ? pulse_wave : '1) &
				(cur_ctrl[sid_pkg::ctrl_bit_saw] ? saw_wave : '1) &
				(cur_ctrl[sid_pkg::ctrl_bit_triangle] ? tri_wave : '1) &
				(cur_ctrl[sid_pkg::ctrl_bit_noise] ? noise_wave : '1);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int v = 0; v < sid_pkg::num_voices; v++) begin
				acc[v] <= sid_pkg::acc_reset;
				lfsr[v] <= sid_pkg::lfsr_reset;
			end
			wave <= '0;
			osc3 <= '0;
		end else if (voice_update) begin
			acc[vsel] <= acc_next;
			// Noise clocks on the rising edge of accumulator bit 19
			if (!cur_acc[19] && acc_next[19])
				lfsr[vsel] <= {cur_lfsr[21:0], cur_lfsr[22] ^ cur_lfsr[17]};
			wave <= wave_next;
			if (vsel == 2'(sid_pkg::num_voices - 1))
				osc3 <= wave_next[sid_pkg::pw_w-1 -: 8];
		end
	end

endmodule

`default_nettype wire

// ==== verilog/sid_envelope.sv ====
// Linear ADSR per voice; level is valid the cycle after voice_update and lags one step behind
`default_nettype none

module sid_envelope (
	input wire clk,
	input wire rst,
	input wire voice_update,
	input wire [1:0] voice,
	input wire [sid_pkg::num_voices-1:0][7:0] ctrl,
	input wire [sid_pkg::num_voices-1:0][7:0] atk_dec,
	input wire [sid_pkg::num_voices-1:0][7:0] sus_rel,
	output logic [sid_pkg::env_w-1:0] level,
	output logic [sid_pkg::env_w-1:0] env3
);

	sid_pkg::env_state_t state [sid_pkg::num_voices];
	logic [14:0] cnt [sid_pkg::num_voices];
	logic [sid_pkg::env_w-1:0] lvl [sid_pkg::num_voices];
	logic [1:0] vsel;
	sid_pkg::env_state_t cur_state;
	logic [sid_pkg::env_w-1:0] cur_lvl;
	logic [sid_pkg::env_w-1:0] sus_lvl;
	logic gate;
	logic [3:0] rate_idx;
	logic env_top;

	assign vsel = (voice < 2'(sid_pkg::num_voices)) ? voice : 2'd0;
	assign cur_state = state[vsel];
	assign cur_lvl = lvl[vsel];
	assign gate = ctrl[vsel][sid_pkg::ctrl_bit_gate];
	// Sustain nibble spans the whole level range
	assign sus_lvl = {2{sus_rel[vsel][7:4]}};
	assign env3 = lvl[sid_pkg::num_voices-1];

	always_comb begin
		case (cur_state)
			sid_pkg::env_attack: rate_idx = atk_dec[vsel][7:4];
			sid_pkg::env_decay_sustain: rate_idx = atk_dec[vsel][3:0];
			default: rate_idx = sus_rel[vsel][3:0];
		endcase
	end

	// A lowered rate must not leave the counter stuck above its period
	assign env_top = (cnt[vsel] >= sid_pkg::rate_table[rate_idx]);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int v = 0; v < sid_pkg::num_voices; v++) begin
				state[v] <= sid_pkg::env_release;
				cnt[v] <= '0;
				lvl[v] <= '0;
			end
			level <= '0;
		end else if (voice_update) begin
			level <= cur_lvl;
			cnt[vsel] <= env_top ? 15'd0 : cnt[vsel] + 15'd1;

			if (!gate)
				state[vsel] <= sid_pkg::env_release;
			else if (cur_state == sid_pkg::env_release)
				state[vsel] <= sid_pkg::env_attack;
			else if (cur_state == sid_pkg::env_attack && cur_lvl == '1)
				state[vsel] <= sid_pkg::env_decay_sustain;

			if (env_top) begin
				case (cur_state)
					sid_pkg::env_attack: begin
						if (cur_lvl != '1)
							lvl[vsel] <= cur_lvl + 1'b1;
					end
					sid_pkg::env_decay_sustain: begin
						// Stops at the sustain level; a raised sustain simply holds
						if (cur_lvl > sus_lvl)
							lvl[vsel] <= cur_lvl - 1'b1;
					end
					default: begin
						if (cur_lvl != '0)
							lvl[vsel] <= cur_lvl - 1'b1;
					end
				endcase
			end
		end
	end

	for (genvar g = 0; g < sid_pkg::num_voices; g++) begin : g_wrap_chk
		a_no_overflow: assert property (@(posedge clk) disable iff (rst)
			lvl[g] == '1 |=> lvl[g] != '0);
		a_no_underflow: assert property (@(posedge clk) disable iff (rst)
			lvl[g] == '0 |=> lvl[g] != '1);
	end

endmodule

`default_nettype wire

// ==== verilog/sid_mixer.sv ====
// Voice mixer; each term is truncated to a quarter step, only bit 7 of mode is honoured
`default_nettype none

module sid_mixer (
	input wire clk,
	input wire rst,
	input wire voice_update,
	input wire [1:0] voice,
	input wire frame_start,
	input wire [sid_pkg::pw_w-1:0] wave,
	input wire [sid_pkg::env_w-1:0] level,
	input wire [7:0] mode,
	output logic [sid_pkg::pw_w-1:0] sample,
	output logic sample_ready
);

	logic upd_d;
	logic [1:0] voice_d;
	logic add_en;
	logic [sid_pkg::pw_w+sid_pkg::env_w-1:0] product;
	logic [sid_pkg::pw_w-1:0] scaled;
	logic [sid_pkg::pw_w+1:0] term;
	logic [sid_pkg::pw_w+1:0] acc;

	// Wave and level arrive one cycle after the slot strobe
	assign add_en = upd_d &&
		!(mode[sid_pkg::mode_three_off] && voice_d == 2'(sid_pkg::num_voices - 1));
	assign product = wave * level;
	assign scaled = product[sid_pkg::pw_w+sid_pkg::env_w-1 -: sid_pkg::pw_w];
	assign term = {2'b00, scaled[sid_pkg::pw_w-1:2], 2'b00};

	always_ff @(posedge clk) begin
		if (rst) begin
			upd_d <= 1'b0;
			voice_d <= '0;
			acc <= '0;
			sample <= '0;
			sample_ready <= 1'b0;
		end else begin
			upd_d <= voice_update;
			voice_d <= voice;
			sample_ready <= frame_start;
			if (frame_start) begin
				sample <= acc[sid_pkg::pw_w+1:2];
				acc <= add_en ? term : '0;
			end else if (add_en) begin
				acc <= acc + term;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/dac_serializer.sv ====
// DAC7611 frame of 36 phases at 4 ticks each; idles at phase 35 until a sample is ready
`default_nettype none

module dac_serializer (
	input wire clk,
	input wire rst,
	input wire tick,
	input wire [sid_pkg::pw_w-1:0] sample,
	input wire sample_ready,
	output logic dac_clk,
	output logic dac_dat,
	output logic dac_le_n,
	output logic dac_cs_n
);

	logic [1:0] tick_cnt;
	logic [5:0] phase;
	logic [15:0] shift;
	logic pending;
	logic phase_en;

	assign phase_en = tick && (tick_cnt == 2'd0);

	always_ff @(posedge clk) begin
		if (rst) begin
			tick_cnt <= '0;
			phase <= 6'd35;
			pending <= 1'b0;
			dac_clk <= 1'b0;
			dac_dat <= 1'b0;
			dac_le_n <= 1'b1;
			dac_cs_n <= 1'b1;
		end else begin
			// The ready pulse falls between phase steps, so hold it
			if (sample_ready)
				pending <= 1'b1;
			if (tick)
				tick_cnt <= tick_cnt + 2'd1;
			if (phase_en) begin
				dac_le_n <= 1'b1;
				if (phase != 6'd35)
					phase <= phase + 6'd1;
				if (phase < 6'd32) begin
					if (phase[0]) begin
						dac_clk <= 1'b1;
					end else begin
						dac_dat <= shift[15];
						shift <= {shift[14:0], 1'b0};
						dac_clk <= 1'b0;
						dac_cs_n <= 1'b0;
					end
				end else if (phase == 6'd32) begin
					// Word done, deselect before the latch pulse
					dac_clk <= 1'b0;
					dac_cs_n <= 1'b1;
				end else if (phase == 6'd33) begin
					dac_le_n <= 1'b0;
				end else if (phase == 6'd35) begin
					dac_cs_n <= 1'b1;
					shift <= {sid_pkg::dac_cmd, sample};
					if (pending || sample_ready) begin
						phase <= 6'd0;
						pending <= 1'b0;
					end
				end
			end
		end
	end

	a_le_deselected: assert property (@(posedge clk) disable iff (rst)
		!dac_le_n |-> dac_cs_n);

endmodule

`default_nettype wire

// ==== verilog/sid_top.sv ====
// SID top level; synchronous active-high reset, plain write strobe, no bus handshake
`default_nettype none

module sid_top (
	input wire clk,
	input wire rst,
	input wire write_en,
	input wire [sid_pkg::addr_w-1:0] addr,
	input wire [7:0] wdata,
	output logic [7:0] rdata,
	output logic dac_clk,
	output logic dac_dat,
	output logic dac_le_n,
	output logic dac_cs_n
);

	logic tick;
	logic [1:0] voice;
	logic voice_update;
	logic frame_start;
	logic [sid_pkg::num_voices-1:0][sid_pkg::freq_w-1:0] freq;
	logic [sid_pkg::num_voices-1:0][sid_pkg::pw_w-1:0] pw;
	logic [sid_pkg::num_voices-1:0][7:0] ctrl;
	logic [sid_pkg::num_voices-1:0][7:0] atk_dec;
	logic [sid_pkg::num_voices-1:0][7:0] sus_rel;
	logic [7:0] mode;
	logic [7:0] osc3;
	logic [sid_pkg::env_w-1:0] env3;
	logic [sid_pkg::pw_w-1:0] wave;
	logic [sid_pkg::env_w-1:0] level;
	logic [sid_pkg::pw_w-1:0] sample;
	logic sample_ready;

	sid_sequencer u_seq (
		.clk(clk), .rst(rst), .tick(tick), .step(),
		.voice(voice), .voice_update(voice_update), .frame_start(frame_start)
	);

	sid_regs u_regs (
		.clk(clk), .rst(rst), .write_en(write_en), .addr(addr), .wdata(wdata),
		.rdata(rdata), .freq(freq), .pw(pw), .ctrl(ctrl), .atk_dec(atk_dec),
		.sus_rel(sus_rel), .mode(mode), .osc3(osc3), .env3(env3)
	);

	sid_oscillator u_osc (
		.clk(clk), .rst(rst), .voice_update(voice_update), .voice(voice),
		.freq(freq), .pw(pw), .ctrl(ctrl), .wave(wave), .osc3(osc3)
	);

	sid_envelope u_env (
		.clk(clk), .rst(rst), .voice_update(voice_update), .voice(voice),
		.ctrl(ctrl), .atk_dec(atk_dec), .sus_rel(sus_rel), .level(level), .env3(env3)
	);

	sid_mixer u_mix (
		.clk(clk), .rst(rst), .voice_update(voice_update), .voice(voice),
		.frame_start(frame_start), .wave(wave), .level(level), .mode(mode),
		.sample(sample), .sample_ready(sample_ready)
	);

	dac_serializer u_dac (
		.clk(clk), .rst(rst), .tick(tick), .sample(sample), .sample_ready(sample_ready),
		.dac_clk(dac_clk), .dac_dat(dac_dat), .dac_le_n(dac_le_n), .dac_cs_n(dac_cs_n)
	);

endmodule

`default_nettype wire

// ==== verif/sid_tb.sv ====
// Directed testbench for sid_top; every test resets the DUT first and a cycle limit bounds the run
`default_nettype none

module sid_tb;
	timeunit 1ns;
	timeprecision 100ps;

	// One voice slot, one envelope step at rate 0, one DAC frame
	localparam int voice_cycles = 48;
	localparam int env_step_cycles = 9 * voice_cycles;
	localparam int frame_cycles = 864;
	localparam int settle_frames = 140;
	localparam int hold_steps = 30;

	// Budgets per test, in clock cycles
	localparam int budget_regs = 400;
	localparam int budget_silence = 4 * frame_cycles;
	localparam int budget_env = (510 + hold_steps) * env_step_cycles;
	localparam int budget_osc = 80 * voice_cycles;
	localparam int budget_mix = (settle_frames + 12) * frame_cycles + 256 * env_step_cycles;
	localparam int budget_sum = budget_regs + budget_silence + budget_env + budget_osc +
		budget_mix;
	localparam int max_cycles = budget_sum + budget_sum / 2;

	// Full-scale pulse at envelope 255 gives (4095 * 255 / 256) / 4 per voice
	localparam int voice_full = (4095 * 255 / 256) / 4;
	localparam logic [15:0] word_silent = 16'h7000;
	localparam logic [15:0] word_one = 16'h7000 + 16'(voice_full);
	localparam logic [15:0] word_two = 16'h7000 + 16'(2 * voice_full);

	logic clk;
	logic rst;
	logic write_en;
	logic [sid_pkg::addr_w-1:0] addr;
	logic [7:0] wdata;
	wire [7:0] rdata;
	wire dac_clk;
	wire dac_dat;
	wire dac_le_n;
	wire dac_cs_n;

	logic [31:0] lfsr_state;
	int errors;
	int failed_tests;

	sid_top UUT (
		.clk(clk), .rst(rst), .write_en(write_en), .addr(addr), .wdata(wdata),
		.rdata(rdata), .dac_clk(dac_clk), .dac_dat(dac_dat),
		.dac_le_n(dac_le_n), .dac_cs_n(dac_cs_n)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		int cycles;
		cycles = 0;
		while (cycles < max_cycles) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: no result after %0d clock cycles", max_cycles);
		$display("Verification failed");
		$finish;
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [7:0] rand_byte();
		logic [7:0] b;
		for (int i = 0; i < 8; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			b = {b[6:0], lfsr_state[0]};
		end
		return b;
	endfunction

	task automatic log_error(input string msg);
		$display("%s", msg);
		errors++;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#5;
		rst = 1'b1;
		write_en = 1'b0;
		repeat (2) @(posedge clk);
		#5;
		rst = 1'b0;
	endtask

	task automatic bus_write(input int a, input logic [7:0] d);
		@(posedge clk);
		#5;
		addr = a[sid_pkg::addr_w-1:0];
		wdata = d;
		write_en = 1'b1;
		@(posedge clk);
		#5;
		write_en = 1'b0;
	endtask

	// Read data is sampled mid-cycle, away from any clock edge
	task automatic bus_read(input int a, output logic [7:0] d);
		@(posedge clk);
		#5;
		addr = a[sid_pkg::addr_w-1:0];
		#10;
		d = rdata;
	endtask

	task automatic capture_dac_word(output logic [15:0] word);
		int nbits;
		logic done;
		nbits = 0;
		done = 1'b0;
		word = '0;
		@(negedge dac_cs_n);
		while (!done) begin
			@(posedge dac_clk or negedge dac_le_n);
			if (!dac_le_n) begin
				done = 1'b1;
			end else if (!dac_cs_n) begin
				word = {word[14:0], dac_dat};
				nbits++;
			end
		end
		if (nbits != 16)
			log_error($sformatf("DAC frame carried %0d bits instead of 16", nbits));
	endtask

	task automatic check_dac_word(input logic [15:0] expected);
		logic [15:0] word;
		// The first word may still hold a sample mixed before the last change
		capture_dac_word(word);
		capture_dac_word(word);
		if (word !== expected)
			log_error($sformatf("Error: dac_dat word expected %h actual %h", expected, word));
	endtask

	task automatic summarize_test(input string name, input int start);
		if (errors == start) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, errors - start);
			failed_tests++;
		end
	endtask

	task automatic registers_readback();
		logic [7:0] written [32];
		logic [7:0] d;
		logic [7:0] expected;
		int start;
		start = errors;
		apply_reset();
		for (int a = 0; a < sid_pkg::num_voices * sid_pkg::voice_stride; a++) begin
			written[a] = rand_byte();
			bus_write(a, written[a]);
		end
		written[sid_pkg::addr_mode] = rand_byte();
		bus_write(sid_pkg::addr_mode, written[sid_pkg::addr_mode]);
		for (int a = 0; a < 32; a++) begin
			if (a < sid_pkg::num_voices * sid_pkg::voice_stride) begin
				expected = written[a];
				// Upper pulse width byte holds only a nibble
				if (a % sid_pkg::voice_stride == sid_pkg::off_pw_hi)
					expected = written[a] & 8'h0f;
			end else if (a == sid_pkg::addr_mode) begin
				expected = written[a];
			end else begin
				expected = 8'h00;
			end
			if (a != sid_pkg::addr_osc3 && a != sid_pkg::addr_env3) begin
				bus_read(a, d);
				if (d !== expected)
					log_error($sformatf("Error: rdata at address %0d expected %h actual %h",
						a, expected, d));
			end
		end
		summarize_test("registers", start);
	endtask

	task automatic silence_after_reset();
		logic [15:0] word;
		int start;
		start = errors;
		apply_reset();
		repeat (3) begin
			capture_dac_word(word);
			if (word !== word_silent)
				log_error($sformatf("Error: dac_dat word expected %h actual %h",
					word_silent, word));
		end
		summarize_test("silence", start);
	endtask

	task automatic envelope_shape();
		logic [7:0] d;
		logic [7:0] prev;
		int base;
		int start;
		start = errors;
		base = 2 * sid_pkg::voice_stride;
		apply_reset();
		bus_write(base + sid_pkg::off_atk_dec, 8'h00);
		bus_write(base + sid_pkg::off_sus_rel, 8'h80);
		bus_write(base + sid_pkg::off_ctrl, 8'h01);
		d = 8'h00;
		prev = 8'h00;
		while (d != 8'hff) begin
			bus_read(sid_pkg::addr_env3, d);
			if (d < prev)
				log_error($sformatf("Error: env3 fell in attack from %h to %h", prev, d));
			prev = d;
		end
		// Sustain nibble 8 gives level 88
		while (d > 8'h88) begin
			bus_read(sid_pkg::addr_env3, d);
			if (d > prev)
				log_error($sformatf("Error: env3 rose in decay from %h to %h", prev, d));
			prev = d;
		end
		if (d !== 8'h88)
			log_error($sformatf("Error: env3 sustain expected 88 actual %h", d));
		repeat (hold_steps) begin
			wait_cycles(env_step_cycles);
			bus_read(sid_pkg::addr_env3, d);
			if (d !== 8'h88)
				log_error($sformatf("Error: env3 hold expected 88 actual %h", d));
		end
		bus_write(base + sid_pkg::off_ctrl, 8'h00);
		while (d != 8'h00) begin
			bus_read(sid_pkg::addr_env3, d);
			if (d > prev)
				log_error($sformatf("Error: env3 rose in release from %h to %h", prev, d));
			prev = d;
		end
		summarize_test("envelope", start);
	endtask

	task automatic oscillator_waves();
		logic [7:0] d;
		logic [7:0] first;
		int changes;
		int base;
		int start;
		start = errors;
		base = 2 * sid_pkg::voice_stride;
		apply_reset();
		bus_write(base + sid_pkg::off_pw_lo, 8'h00);
		bus_write(base + sid_pkg::off_pw_hi, 8'h00);
		bus_write(base + sid_pkg::off_ctrl, 8'h40);
		wait_cycles(2 * voice_cycles);
		bus_read(sid_pkg::addr_osc3, d);
		if (d !== 8'hff)
			log_error($sformatf("Error: osc3 pulse expected ff actual %h", d));
		bus_write(base + sid_pkg::off_ctrl, 8'h00);
		wait_cycles(2 * voice_cycles);
		bus_read(sid_pkg::addr_osc3, d);
		if (d !== 8'h00)
			log_error($sformatf("Error: osc3 no waveform expected 00 actual %h", d));
		// High byte of 10 or more moves the top byte within 16 updates
		bus_write(base + sid_pkg::off_freq_lo, rand_byte());
		bus_write(base + sid_pkg::off_freq_hi, (rand_byte() & 8'h7f) | 8'h10);
		bus_write(base + sid_pkg::off_ctrl, 8'h20);
		wait_cycles(2 * voice_cycles);
		bus_read(sid_pkg::addr_osc3, first);
		changes = 0;
		repeat (4) begin
			wait_cycles(16 * voice_cycles);
			bus_read(sid_pkg::addr_osc3, d);
			if (d != first)
				changes++;
		end
		if (changes == 0)
			log_error("osc3 kept one value while the sawtooth was running");
		summarize_test("oscillator", start);
	endtask

	task automatic mix_levels();
		logic [7:0] d;
		int base;
		int start;
		start = errors;
		base = 2 * sid_pkg::voice_stride;
		apply_reset();
		// Voice 1 alone, pulse at pw 0 and full sustain
		bus_write(sid_pkg::off_atk_dec, 8'h00);
		bus_write(sid_pkg::off_sus_rel, 8'hf0);
		bus_write(sid_pkg::off_ctrl, 8'h41);
		wait_cycles(settle_frames * frame_cycles);
		check_dac_word(word_one);
		// Voice 3 joins with the same setup but muted
		bus_write(sid_pkg::addr_mode, 8'h80);
		bus_write(base + sid_pkg::off_atk_dec, 8'h00);
		bus_write(base + sid_pkg::off_sus_rel, 8'hf0);
		bus_write(base + sid_pkg::off_ctrl, 8'h41);
		d = 8'h00;
		while (d != 8'hff)
			bus_read(sid_pkg::addr_env3, d);
		check_dac_word(word_one);
		bus_write(sid_pkg::addr_mode, 8'h00);
		check_dac_word(word_two);
		summarize_test("mix level", start);
	endtask

	initial begin
		rst = 1'b1;
		write_en = 1'b0;
		addr = '0;
		wdata = '0;
		lfsr_state = 32'h44cc;
		errors = 0;
		failed_tests = 0;
		registers_readback();
		silence_after_reset();
		envelope_shape();
		oscillator_waves();
		mix_levels();
		$display("Summary: 5 tests, %0d failing, %0d errors", failed_tests, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
verilog/sid_pkg.sv
verilog/sid_sequencer.sv
verilog/sid_regs.sv
verilog/sid_oscillator.sv
verilog/sid_envelope.sv
verilog/sid_mixer.sv
verilog/dac_serializer.sv
verilog/sid_top.sv
verif/sid_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert --timescale 1ns/100ps
TOP = sid_tb
FILELIST = verilog.f
OBJDIR = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
